// ==== verilog/rv_pkg.sv ====
package rv_pkg;

	typedef logic [31:0] word_t;     // data word or byte address
	typedef logic [4:0]  reg_addr_t;
	typedef logic [1:0]  pc_sel_t;   // passed through to fetch

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_pass_b
	} alu_fn_t;

	// writeback source, encoded as the issue stage sends it
	typedef enum logic [2:0] {
		wb_alu    = 3'd0,
		wb_link   = 3'd1,
		wb_muldiv = 3'd2,
		wb_upper  = 3'd3,
		wb_mem    = 3'd4,
		wb_auipc  = 3'd5
	} wb_sel_t;

	typedef enum logic [3:0] {
		mem_none,
		mem_lb,
		mem_lh,
		mem_lw,
		mem_lbu,
		mem_lhu,
		mem_sb,
		mem_sh,
		mem_sw
	} mem_op_t;

	typedef enum logic [2:0] {
		md_mul,
		md_mulh,
		md_mulhsu,
		md_mulhu,
		md_div,
		md_divu,
		md_rem,
		md_remu
	} md_op_t;

endpackage

// ==== verilog/piton_pkg.sv ====
package piton_pkg;

	typedef logic [5:0] l15_rqtype_t;
	typedef logic [2:0] l15_size_t;
	typedef logic [3:0] l15_rtntype_t;

	// request types
	localparam l15_rqtype_t l15_load_rq  = 6'b000000;
	localparam l15_rqtype_t l15_store_rq = 6'b000001;

	// access sizes
	localparam l15_size_t l15_size_1b = 3'b001;
	localparam l15_size_t l15_size_2b = 3'b010;
	localparam l15_size_t l15_size_4b = 3'b011;

	// return types on the response side
	localparam l15_rtntype_t l15_load_ret = 4'b0000;
	localparam l15_rtntype_t l15_st_ack   = 4'b0100;

endpackage

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu (
	input  rv_pkg::alu_fn_t alu_fn,
	input  rv_pkg::word_t   operand_a,
	input  rv_pkg::word_t   operand_b,
	input  logic            bneq,
	input  logic            btype,
	output rv_pkg::word_t   result,
	output logic            btaken
);
	import rv_pkg::*;

	logic [4:0] shamt;
	logic       cmp;

	assign shamt = operand_b[4:0];

	always_comb
	begin
		case (alu_fn)
			alu_add:    result = operand_a + operand_b;
			alu_sub:    result = operand_a - operand_b;
			alu_sll:    result = operand_a << shamt;
			alu_slt:    result = {31'b0, $signed(operand_a) < $signed(operand_b)};
			alu_sltu:   result = {31'b0, operand_a < operand_b};
			alu_xor:    result = operand_a ^ operand_b;
			alu_srl:    result = operand_a >> shamt;
			alu_sra:    result = $signed(operand_a) >>> shamt;
			alu_or:     result = operand_a | operand_b;
			alu_and:    result = operand_a & operand_b;
			alu_pass_b: result = operand_b; // lui style pass
			default:    result = '0;
		endcase
	end

	// sub compares for equality, slt/sltu for less-than
	always_comb
	begin
		case (alu_fn)
			alu_sub:  cmp = (operand_a == operand_b);
			alu_slt:  cmp = $signed(operand_a) < $signed(operand_b);
			alu_sltu: cmp = operand_a < operand_b;
			default:  cmp = 1'b0;
		endcase
	end

	assign btaken = btype & (cmp ^ bneq); // bne, bge, bgeu invert
endmodule

// ==== verilog/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
	input  rv_pkg::word_t pc,
	input  rv_pkg::word_t operand_a,
	input  rv_pkg::word_t b_imm,
	input  rv_pkg::word_t j_imm,
	input  rv_pkg::word_t i_imm,
	input  logic          btaken,
	input  logic          j,
	input  logic          jr,
	output rv_pkg::word_t target
);

	// jr beats j beats a taken branch
	always_comb
	begin
		if (jr)
		begin
			target    = operand_a + i_imm;
			target[0] = 1'b0;
		end
		else if (j)
			target = pc + j_imm;
		else if (btaken)
			target = pc + b_imm;
		else
			target = pc + 32'd1; // fall through, pc counts instructions
	end
endmodule

// ==== verilog/mul_div.sv ====
`timescale 1ns/1ps

module mul_div (
	input  rv_pkg::word_t  a,
	input  rv_pkg::word_t  b,
	input  rv_pkg::md_op_t md_op,
	output rv_pkg::word_t  res
);
	import rv_pkg::*;

	logic signed [32:0] a_ext;
	logic signed [32:0] b_ext;
	logic signed [65:0] prod;
	logic               div_zero;
	logic               div_ovf;

	// one signed 33x33 multiplier covers all four products
	assign a_ext = {(md_op == md_mulh || md_op == md_mulhsu) & a[31], a};
	assign b_ext = {(md_op == md_mulh) & b[31], b};
	assign prod  = a_ext * b_ext;

	assign div_zero = (b == '0);
	assign div_ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);

	always_comb
	begin
		unique case (md_op)
			md_mul:                       res = prod[31:0];
			md_mulh, md_mulhsu, md_mulhu: res = prod[63:32];
			md_div:
				if (div_zero)
					res = '1;
				else if (div_ovf)
					res = a; // most negative / -1
				else
					res = $signed(a) / $signed(b);
			md_divu: res = div_zero ? '1 : a / b;
			md_rem:
				if (div_zero)
					res = a;
				else if (div_ovf)
					res = '0;
				else
					res = $signed(a) % $signed(b);
			md_remu: res = div_zero ? a : a % b;
		endcase
	end
endmodule

// ==== verilog/mem_interface.sv ====
`timescale 1ns/1ps

module mem_interface (
	input  logic            clk,
	input  logic            nrst,
	input  logic            hold,
	input  rv_pkg::mem_op_t mem_op4,
	input  rv_pkg::word_t   op_a4,
	input  rv_pkg::word_t   op_b4,
	input  rv_pkg::word_t   s_imm4,
	input  rv_pkg::word_t   i_imm4,
	output rv_pkg::word_t   addr6,
	output rv_pkg::word_t   data_in6,
	output logic [3:0]      byte_en6,
	output logic            is_load6,
	output logic            is_store6,
	output rv_pkg::mem_op_t m_op6,
	input  rv_pkg::word_t   piton_out,
	output rv_pkg::word_t   mem_out6
);
	import rv_pkg::*;

	word_t      ea4;
	word_t      st_data4;
	logic [3:0] be4;
	mem_op_t    m_op5;
	logic [1:0] lane6;      // byte offset of the access in stage 6
	logic [7:0] ld_byte;
	logic [15:0] ld_half;

	always_comb
	begin
		ea4      = op_a4 + ((mem_op4 inside {mem_sb, mem_sh, mem_sw}) ? s_imm4 : i_imm4);
		st_data4 = op_b4;
		be4      = 4'b1111;
		case (mem_op4)
			mem_lb, mem_lbu, mem_sb:
			begin
				be4      = 4'b0001 << ea4[1:0];
				st_data4 = {4{op_b4[7:0]}};
			end
			mem_lh, mem_lhu, mem_sh:
			begin
				ea4[0]   = 1'b0; // force half alignment
				be4      = ea4[1] ? 4'b1100 : 4'b0011;
				st_data4 = {2{op_b4[15:0]}};
			end
			default: ea4[1:0] = 2'b00;
		endcase
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			m_op5 <= mem_none;
			m_op6 <= mem_none;
		end
		else if (!hold)
		begin
			m_op5 <= mem_op4;
			m_op6 <= m_op5;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!hold)
		begin
			addr6    <= ea4;
			data_in6 <= st_data4;
			byte_en6 <= be4;
			lane6    <= addr6[1:0];
		end
	end

	assign is_load6  = m_op5 inside {mem_lb, mem_lh, mem_lw, mem_lbu, mem_lhu};
	assign is_store6 = m_op5 inside {mem_sb, mem_sh, mem_sw};

	// load formatting on the returned word
	assign ld_byte = piton_out[8*lane6 +: 8];
	assign ld_half = lane6[1] ? piton_out[31:16] : piton_out[15:0];

	always_comb
	begin
		case (m_op6)
			mem_lb:  mem_out6 = {{24{ld_byte[7]}}, ld_byte};
			mem_lbu: mem_out6 = {24'b0, ld_byte};
			mem_lh:  mem_out6 = {{16{ld_half[15]}}, ld_half};
			mem_lhu: mem_out6 = {16'b0, ld_half};
			default: mem_out6 = piton_out;
		endcase
	end
endmodule

// ==== verilog/core_piton.sv ====
`timescale 1ns/1ps

module core_piton #(
	parameter int resp_timeout = 64
) (
	input  logic                     clk,
	input  logic                     nrst,
	input  rv_pkg::word_t            addr6,
	input  rv_pkg::word_t            data_in6,
	input  logic [3:0]               byte_en6,
	input  logic                     is_load6,
	input  logic                     is_store6,
	output piton_pkg::l15_rqtype_t   core_l15_rqtype,
	output piton_pkg::l15_size_t     core_l15_size,
	output rv_pkg::word_t            core_l15_address,
	output rv_pkg::word_t            core_l15_data,
	output logic                     core_l15_val,
	input  rv_pkg::word_t            l15_core_data_0,
	input  piton_pkg::l15_rtntype_t  l15_core_returntype,
	input  logic                     l15_core_val,
	input  logic                     l15_core_header_ack,
	output rv_pkg::word_t            piton_out,
	output logic                     busy,
	output logic                     mem_error
);
	import piton_pkg::*;

	typedef enum logic [1:0] {idle, req, wait_resp, done} state_t;

	localparam int cnt_w = $clog2(resp_timeout + 1);

	state_t           state;
	state_t           next_state;
	logic             start;
	logic             resp_ok;
	logic [cnt_w-1:0] wait_cnt;
	l15_size_t        size_code;

	// a new access is taken only when no request is outstanding
	assign start   = (state == idle || state == done) && (is_load6 || is_store6);
	assign resp_ok = l15_core_val &&
		(l15_core_returntype == l15_load_ret || l15_core_returntype == l15_st_ack);

	always_comb
	begin
		next_state = state;
		case (state)
			idle, done: next_state = start ? req : idle;
			req:        if (l15_core_header_ack) next_state = wait_resp;
			wait_resp:  if (resp_ok) next_state = done;
			default:    next_state = idle;
		endcase
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			state <= idle;
		else
			state <= next_state;
	end

	always_comb
	begin
		case (byte_en6)
			4'b0001, 4'b0010, 4'b0100, 4'b1000: size_code = l15_size_1b;
			4'b0011, 4'b1100:                   size_code = l15_size_2b;
			default:                            size_code = l15_size_4b;
		endcase
	end

	// request fields stay put from start until the header ack
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			core_l15_rqtype  <= is_store6 ? l15_store_rq : l15_load_rq;
			core_l15_size    <= size_code;
			core_l15_address <= addr6;
			core_l15_data    <= data_in6;
		end
		if (state == wait_resp && l15_core_val && l15_core_returntype == l15_load_ret)
			piton_out <= l15_core_data_0;
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			wait_cnt  <= '0;
			mem_error <= 1'b0;
		end
		else if (state != wait_resp)
			wait_cnt <= '0;
		else if (wait_cnt != cnt_w'(resp_timeout))
			wait_cnt <= wait_cnt + cnt_w'(1);
		else
			mem_error <= 1'b1; // stays set until reset
	end

	assign core_l15_val = (state == req);
	assign busy         = (state == req) || (state == wait_resp);
endmodule

// ==== verilog/exe_stage.sv ====
`timescale 1ns/1ps

module exe_stage #(
	parameter int resp_timeout = 64
) (
	input  logic                    clk,
	input  logic                    nrst,
	input  rv_pkg::word_t           op_a,
	input  rv_pkg::word_t           op_b,       // also the i-type immediate
	input  rv_pkg::reg_addr_t       rd4,
	input  logic                    we4,
	input  rv_pkg::alu_fn_t         alu_fn4,
	input  rv_pkg::wb_sel_t         wb_sel4,
	input  rv_pkg::word_t           b_imm4,
	input  rv_pkg::word_t           j_imm4,
	input  rv_pkg::word_t           u_imm4,
	input  rv_pkg::word_t           s_imm4,
	input  logic                    bneq4,
	input  logic                    btype4,
	input  logic                    j4,
	input  logic                    jr4,
	input  rv_pkg::mem_op_t         mem_op4,
	input  rv_pkg::md_op_t          md_op4,
	input  rv_pkg::word_t           pc4,
	input  rv_pkg::pc_sel_t         pcselect4,
	output rv_pkg::word_t           wb_data6,
	output logic                    we6,
	output rv_pkg::reg_addr_t       rd6,
	output rv_pkg::word_t           target,
	output logic                    bjtaken6,
	output rv_pkg::pc_sel_t         pcselect5,
	output logic                    busy,
	output logic                    mem_error,
	output piton_pkg::l15_rqtype_t  core_l15_rqtype,
	output piton_pkg::l15_size_t    core_l15_size,
	output rv_pkg::word_t           core_l15_address,
	output rv_pkg::word_t           core_l15_data,
	output logic                    core_l15_val,
	input  rv_pkg::word_t           l15_core_data_0,
	input  piton_pkg::l15_rtntype_t l15_core_returntype,
	input  logic                    l15_core_val,
	input  logic                    l15_core_header_ack
);
	import rv_pkg::*;

	word_t      alu_res4;
	logic       btaken4;
	word_t      md_res5;
	word_t      alu_res5;
	word_t      opa5;
	word_t      opb5;
	word_t      u_imm5;
	word_t      pc5;
	md_op_t     md_op5;
	wb_sel_t    wb_sel5;
	reg_addr_t  rd5;
	logic       we5;
	word_t      alu_res6;
	word_t      md_res6;
	word_t      u_imm6;
	word_t      auipc6;
	word_t      link6;
	wb_sel_t    wb_sel6;
	logic       we_reg6;
	word_t      mem_out6;
	word_t      addr6;
	word_t      data_in6;
	word_t      piton_out;
	logic [3:0] byte_en6;
	logic       is_load6;
	logic       is_store6;
	mem_op_t    m_op6;

	// branch compare runs on the issue-stage operands so fetch gets it this cycle
	alu exe_alu (
		.alu_fn    (alu_fn4),
		.operand_a (op_a),
		.operand_b (op_b),
		.bneq      (bneq4),
		.btype     (btype4),
		.result    (alu_res4),
		.btaken    (btaken4)
	);

	branch_unit exe_bu (
		.pc        (pc4),
		.operand_a (op_a),
		.b_imm     (b_imm4),
		.j_imm     (j_imm4),
		.i_imm     (op_b),
		.btaken    (btaken4),
		.j         (j4),
		.jr        (jr4),
		.target    (target)
	);

	mul_div exe_md (
		.a     (opa5),
		.b     (opb5),
		.md_op (md_op5),
		.res   (md_res5)
	);

	mem_interface dmem_if (
		.clk       (clk),
		.nrst      (nrst),
		.hold      (busy),
		.mem_op4   (mem_op4),
		.op_a4     (op_a),
		.op_b4     (op_b),     // store data
		.s_imm4    (s_imm4),
		.i_imm4    (op_b),     // load offset
		.addr6     (addr6),
		.data_in6  (data_in6),
		.byte_en6  (byte_en6),
		.is_load6  (is_load6),
		.is_store6 (is_store6),
		.m_op6     (m_op6),
		.piton_out (piton_out),
		.mem_out6  (mem_out6)
	);

	core_piton #(
		.resp_timeout (resp_timeout)
	) l15_port (
		.clk                 (clk),
		.nrst                (nrst),
		.addr6               (addr6),
		.data_in6            (data_in6),
		.byte_en6            (byte_en6),
		.is_load6            (is_load6),
		.is_store6           (is_store6),
		.core_l15_rqtype     (core_l15_rqtype),
		.core_l15_size       (core_l15_size),
		.core_l15_address    (core_l15_address),
		.core_l15_data       (core_l15_data),
		.core_l15_val        (core_l15_val),
		.l15_core_data_0     (l15_core_data_0),
		.l15_core_returntype (l15_core_returntype),
		.l15_core_val        (l15_core_val),
		.l15_core_header_ack (l15_core_header_ack),
		.piton_out           (piton_out),
		.busy                (busy),
		.mem_error           (mem_error)
	);

	// pipe control, frozen while a memory access is outstanding
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			we5     <= 1'b0;
			we_reg6 <= 1'b0;
			wb_sel5 <= wb_alu;
			wb_sel6 <= wb_alu;
		end
		else if (!busy)
		begin
			we5     <= we4;
			we_reg6 <= we5;
			wb_sel5 <= wb_sel4;
			wb_sel6 <= wb_sel5;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!busy)
		begin
			alu_res5 <= alu_res4;
			opa5     <= op_a;
			opb5     <= op_b;
			u_imm5   <= u_imm4;
			pc5      <= pc4;
			md_op5   <= md_op4;
			rd5      <= rd4;
			alu_res6 <= alu_res5;
			md_res6  <= md_res5;
			u_imm6   <= u_imm5;
			auipc6   <= pc5 + u_imm5;
			link6    <= pc5 + 32'd1; // next instruction
			rd6      <= rd5;
		end
	end

	always_comb
	begin
		unique case (wb_sel6)
			wb_alu:    wb_data6 = alu_res6;
			wb_link:   wb_data6 = link6;
			wb_muldiv: wb_data6 = md_res6;
			wb_upper:  wb_data6 = u_imm6;
			wb_mem:    wb_data6 = mem_out6;
			wb_auipc:  wb_data6 = auipc6;
			default:   wb_data6 = '0;
		endcase
	end

	// a store never writes back, a load waits for its data
	assign we6       = we_reg6 && !busy && !(m_op6 inside {mem_sb, mem_sh, mem_sw});
	assign bjtaken6  = btaken4 | j4 | jr4;
	assign pcselect5 = pcselect4;
endmodule

// ==== verif/exe_stage_assertions.sv ====
`timescale 1ns/1ps

module exe_stage_assertions (
	input logic                   clk,
	input logic                   nrst,
	input logic                   core_l15_val,
	input logic                   l15_core_header_ack,
	input logic                   l15_core_val,
	input piton_pkg::l15_rqtype_t core_l15_rqtype,
	input piton_pkg::l15_size_t   core_l15_size,
	input rv_pkg::word_t          core_l15_address,
	input rv_pkg::word_t          core_l15_data,
	input logic                   we6,
	input logic                   busy
);

	logic txn_open; // request seen, response still to come

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			txn_open <= 1'b0;
		else if (l15_core_val)
			txn_open <= 1'b0;
		else if (core_l15_val)
			txn_open <= 1'b1;
	end

	// request held until the L1.5 takes the header
	req_hold: assert property (@(posedge clk) disable iff (!nrst)
		core_l15_val && !l15_core_header_ack |=> core_l15_val &&
		$stable(core_l15_rqtype) && $stable(core_l15_size) &&
		$stable(core_l15_address) && $stable(core_l15_data))
		else $error("request changed before header ack");

	// stall covers the whole access, no writeback meanwhile
	no_wb_busy: assert property (@(posedge clk) disable iff (!nrst)
		(core_l15_val || txn_open) |-> (busy && !we6))
		else $error("writeback or no stall while an access is open");

	reset_idle: assert property (@(posedge clk) !nrst |-> !core_l15_val)
		else $error("request valid during reset");
endmodule

bind exe_stage exe_stage_assertions exe_stage_chk (
	.clk                 (clk),
	.nrst                (nrst),
	.core_l15_val        (core_l15_val),
	.l15_core_header_ack (l15_core_header_ack),
	.l15_core_val        (l15_core_val),
	.core_l15_rqtype     (core_l15_rqtype),
	.core_l15_size       (core_l15_size),
	.core_l15_address    (core_l15_address),
	.core_l15_data       (core_l15_data),
	.we6                 (we6),
	.busy                (busy)
);

// ==== verif/exe_stage_tb.sv ====
`timescale 1ns/1ps

module exe_stage_tb;
	import rv_pkg::*;
	import piton_pkg::*;

	logic clk = 1'b0;
	logic nrst = 1'b0;
	word_t op_a = '0;
	word_t op_b = '0;
	reg_addr_t rd4 = '0;
	logic we4 = 1'b0;
	alu_fn_t alu_fn4 = alu_add;
	wb_sel_t wb_sel4 = wb_alu;
	word_t b_imm4 = '0;
	word_t j_imm4 = '0;
	word_t u_imm4 = '0;
	word_t s_imm4 = '0;
	logic bneq4 = 1'b0;
	logic btype4 = 1'b0;
	logic j4 = 1'b0;
	logic jr4 = 1'b0;
	mem_op_t mem_op4 = mem_none;
	md_op_t md_op4 = md_mul;
	word_t pc4 = '0;
	pc_sel_t pcselect4 = '0;
	word_t l15_core_data_0 = '0;
	l15_rtntype_t l15_core_returntype = '0;
	logic l15_core_val = 1'b0;
	logic l15_core_header_ack = 1'b0;

	word_t wb_data6;
	logic we6;
	reg_addr_t rd6;
	word_t target;
	logic bjtaken6;
	pc_sel_t pcselect5;
	logic busy;
	logic mem_error;
	l15_rqtype_t core_l15_rqtype;
	l15_size_t core_l15_size;
	word_t core_l15_address;
	word_t core_l15_data;
	logic core_l15_val;

	// responder state and its copy of the last request header
	logic [1:0] rsp_state = 2'd0;
	int rsp_cnt = 0;
	word_t mem_arr [16];
	logic got_ack = 1'b0;
	l15_rqtype_t cap_rqtype = '0;
	l15_size_t cap_size = '0;
	word_t cap_addr = '0;
	word_t cap_data = '0;

	logic q_we [$];
	reg_addr_t q_rd [$];
	word_t q_data [$];
	int errors = 0;
	int test_errs = 0;
	int test_checks = 0;
	int tests_run = 0;
	int tests_failed = 0;

	exe_stage #(
		.resp_timeout (64)
	) exe_stage_inst (.*);

	always #10 clk = ~clk;

	function automatic logic lane_hit(l15_size_t size, logic [1:0] off, int k);
		if (size == l15_size_1b)
			return k == int'(off);
		else if (size == l15_size_2b)
			return (k / 2) == int'(off[1]);
		return 1'b1;
	endfunction

	// L1.5 side: ack after 0..3 cycles, answer 1..4 cycles later
	always @(posedge clk)
	begin
		if (!nrst)
		begin
			rsp_state <= 2'd0;
			l15_core_header_ack <= 1'b0;
			l15_core_val <= 1'b0;
			got_ack <= 1'b0;
			for (int i = 0; i < 16; i++)
				mem_arr[i] <= 32'h9e37_79b9 * (i + 1);
		end
		else
		begin
			case (rsp_state)
				2'd0:
					if (core_l15_val)
					begin
						got_ack <= 1'b0;
						rsp_cnt <= $urandom_range(3, 0);
						rsp_state <= 2'd1;
					end
				2'd1:
					if (rsp_cnt == 0)
					begin
						l15_core_header_ack <= 1'b1;
						got_ack <= 1'b1;
						cap_rqtype <= core_l15_rqtype;
						cap_size <= core_l15_size;
						cap_addr <= core_l15_address;
						cap_data <= core_l15_data;
						if (core_l15_rqtype == l15_store_rq)
							for (int k = 0; k < 4; k++)
								if (lane_hit(core_l15_size, core_l15_address[1:0], k))
									mem_arr[core_l15_address[5:2]][8*k +: 8] <=
										core_l15_data[8*k +: 8];
						rsp_cnt <= $urandom_range(4, 1);
						rsp_state <= 2'd2;
					end
					else
						rsp_cnt <= rsp_cnt - 1;
				2'd2:
				begin
					l15_core_header_ack <= 1'b0;
					if (rsp_cnt == 1)
					begin
						l15_core_val <= 1'b1;
						l15_core_returntype <= (cap_rqtype == l15_store_rq) ?
							l15_st_ack : l15_load_ret;
						l15_core_data_0 <= mem_arr[core_l15_address[5:2]];
						rsp_state <= 2'd3;
					end
					else
						rsp_cnt <= rsp_cnt - 1;
				end
				default:
				begin
					l15_core_val <= 1'b0;
					rsp_state <= 2'd0;
				end
			endcase
		end
	end

	function automatic word_t alu_model(alu_fn_t fn, word_t a, word_t b);
		word_t r;
		case (fn)
			alu_add:  r = a + b;
			alu_sub:  r = a - b;
			alu_sll:  r = a << b[4:0];
			alu_slt:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			alu_sltu: r = (a < b) ? 32'd1 : 32'd0;
			alu_xor:  r = a ^ b;
			alu_srl:  r = a >> b[4:0];
			alu_sra:  r = $signed(a) >>> b[4:0];
			alu_or:   r = a | b;
			alu_and:  r = a & b;
			default:  r = b;
		endcase
		return r;
	endfunction

	function automatic word_t md_model(md_op_t op, word_t a, word_t b);
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		logic [63:0] p;
		word_t sq;
		word_t sr;
		logic ovf;
		sa = {{32{a[31]}}, a};
		sb = {{32{b[31]}}, b};
		sq = $signed(a) / $signed(b);
		sr = $signed(a) % $signed(b);
		ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
		case (op)
			md_mul:    return a * b;
			md_mulh:   p = sa * sb;
			md_mulhsu: p = sa * $signed({32'b0, b});
			md_mulhu:  p = {32'b0, a} * {32'b0, b};
			md_div:    return (b == 0) ? 32'hffff_ffff : (ovf ? a : sq);
			md_divu:   return (b == 0) ? 32'hffff_ffff : a / b;
			md_rem:    return (b == 0) ? a : (ovf ? 32'd0 : sr);
			default:   return (b == 0) ? a : a % b;
		endcase
		return p[63:32];
	endfunction

	function automatic word_t align_addr(mem_op_t op, word_t ea);
		if (op inside {mem_lh, mem_lhu, mem_sh})
			return {ea[31:1], 1'b0};
		else if (op inside {mem_lw, mem_sw})
			return {ea[31:2], 2'b00};
		return ea;
	endfunction

	function automatic word_t load_model(mem_op_t op, word_t w, logic [1:0] off);
		logic [7:0] b8;
		logic [15:0] h;
		b8 = w[8*off +: 8];
		h = off[1] ? w[31:16] : w[15:0];
		case (op)
			mem_lb:  return {{24{b8[7]}}, b8};
			mem_lbu: return {24'b0, b8};
			mem_lh:  return {{16{h[15]}}, h};
			mem_lhu: return {16'b0, h};
			default: return w;
		endcase
	endfunction

	task automatic report_value(string name, word_t exp, word_t act);
		$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
		test_errs++;
	endtask

	task automatic note_fault(string what);
		$display("%s", what);
		test_errs++;
	endtask

	task automatic end_test(string name);
		tests_run++;
		errors += test_errs;
		if (test_errs != 0)
			tests_failed++;
		$display("test %s: %0d checks, %0d errors", name, test_checks, test_errs);
		test_errs = 0;
		test_checks = 0;
	endtask

	task automatic set_nop();
		op_a <= '0;
		op_b <= '0;
		rd4 <= '0;
		we4 <= 1'b0;
		alu_fn4 <= alu_add;
		wb_sel4 <= wb_alu;
		b_imm4 <= '0;
		j_imm4 <= '0;
		u_imm4 <= '0;
		s_imm4 <= '0;
		bneq4 <= 1'b0;
		btype4 <= 1'b0;
		j4 <= 1'b0;
		jr4 <= 1'b0;
		mem_op4 <= mem_none;
		md_op4 <= md_mul;
		pc4 <= '0;
	endtask

	task automatic push_exp(logic we, reg_addr_t rd, word_t d);
		q_we.push_back(we);
		q_rd.push_back(rd);
		q_data.push_back(d);
	endtask

	// result of the instruction driven two edges ago
	task automatic check_step(string name);
		logic exp_we;
		reg_addr_t exp_rd;
		word_t exp_d;
		@(negedge clk);
		if (q_we.size() == 3)
		begin
			exp_we = q_we.pop_front();
			exp_rd = q_rd.pop_front();
			exp_d = q_data.pop_front();
			test_checks++;
			if (we6 !== exp_we)
				report_value({name, " we6"}, 32'(exp_we), 32'(we6));
			else if (rd6 !== exp_rd)
				report_value({name, " rd6"}, 32'(exp_rd), 32'(rd6));
			else if (exp_we && wb_data6 !== exp_d)
				report_value(name, exp_d, wb_data6);
		end
	endtask

	task automatic drain(string name);
		repeat (2)
		begin
			@(posedge clk);
			set_nop();
			push_exp(1'b0, '0, '0);
			check_step(name);
		end
		q_we.delete();
		q_rd.delete();
		q_data.delete();
	endtask

	task automatic alu_test();
		alu_fn_t fn;
		word_t a;
		word_t b;
		reg_addr_t rd;
		logic we;
		for (int i = 0; i < 500; i++)
		begin
			fn = alu_fn_t'($urandom_range(10, 0));
			a = $urandom;
			b = $urandom;
			rd = reg_addr_t'($urandom);
			we = 1'($urandom);
			@(posedge clk);
			set_nop();
			op_a <= a;
			op_b <= b;
			alu_fn4 <= fn;
			rd4 <= rd;
			we4 <= we;
			push_exp(we, rd, alu_model(fn, a, b));
			check_step("alu");
		end
		drain("alu");
		end_test("alu");
	endtask

	task automatic branch_test();
		alu_fn_t fn;
		word_t a;
		word_t b;
		word_t pc;
		word_t bi;
		word_t ji;
		word_t tgt;
		pc_sel_t psel;
		logic neq;
		logic cmp;
		logic taken;
		int kind;
		for (int i = 0; i < 300; i++)
		begin
			kind = $urandom_range(3, 0); // 0 jr, 1 j, else conditional branch
			fn = ($urandom_range(2, 0) == 0) ? alu_sub : ($urandom_range(1, 0) ? alu_slt : alu_sltu);
			a = $urandom;
			b = ($urandom_range(3, 0) == 0) ? a : $urandom;
			pc = $urandom;
			bi = $urandom;
			ji = $urandom;
			psel = pc_sel_t'($urandom);
			neq = 1'($urandom);
			@(posedge clk);
			set_nop();
			op_a <= a;
			op_b <= b;
			alu_fn4 <= fn;
			bneq4 <= neq;
			btype4 <= (kind > 1);
			j4 <= (kind == 1);
			jr4 <= (kind == 0);
			pc4 <= pc;
			b_imm4 <= bi;
			j_imm4 <= ji;
			pcselect4 <= psel;
			@(negedge clk);
			if (fn == alu_sub)
				cmp = (a == b);
			else if (fn == alu_slt)
				cmp = $signed(a) < $signed(b);
			else
				cmp = a < b;
			taken = (kind > 1) && (cmp != neq);
			if (kind == 0)
				tgt = (a + b) & 32'hffff_fffe;
			else if (kind == 1)
				tgt = pc + ji;
			else
				tgt = taken ? pc + bi : pc + 32'd1;
			test_checks++;
			if (bjtaken6 !== (taken || kind < 2))
				report_value("branch bjtaken6", 32'(taken || kind < 2), 32'(bjtaken6));
			if (target !== tgt)
				report_value("branch target", tgt, target);
			if (pcselect5 !== psel)
				report_value("branch pcselect5", 32'(psel), 32'(pcselect5));
		end
		end_test("branch");
	endtask

	task automatic muldiv_test();
		md_op_t op;
		word_t a;
		word_t b;
		reg_addr_t rd;
		for (int i = 0; i < 400; i++)
		begin
			op = md_op_t'($urandom_range(7, 0));
			a = $urandom;
			b = $urandom;
			if (i % 10 == 0)
				b = '0;
			else if (i % 10 == 1)
			begin
				a = 32'h8000_0000;
				b = 32'hffff_ffff;
			end
			else if (i % 10 == 2)
				b = $urandom_range(9, 1);
			rd = reg_addr_t'($urandom);
			@(posedge clk);
			set_nop();
			op_a <= a;
			op_b <= b;
			md_op4 <= op;
			wb_sel4 <= wb_muldiv;
			rd4 <= rd;
			we4 <= 1'b1;
			push_exp(1'b1, rd, md_model(op, a, b));
			check_step("muldiv");
		end
		drain("muldiv");
		end_test("muldiv");
	endtask

	task automatic upper_test();
		word_t pc;
		word_t u;
		reg_addr_t rd;
		int kind;
		for (int i = 0; i < 150; i++)
		begin
			kind = $urandom_range(2, 0);
			pc = $urandom;
			u = $urandom & 32'hffff_f000;
			rd = reg_addr_t'($urandom);
			@(posedge clk);
			set_nop();
			pc4 <= pc;
			u_imm4 <= u;
			rd4 <= rd;
			we4 <= 1'b1;
			j4 <= (kind == 2);
			wb_sel4 <= (kind == 0) ? wb_upper : ((kind == 1) ? wb_auipc : wb_link);
			push_exp(1'b1, rd, (kind == 0) ? u : ((kind == 1) ? pc + u : pc + 32'd1));
			check_step("upper");
		end
		drain("upper");
		end_test("upper");
	endtask

	// waits for busy to rise and fall, checking the port while it is high
	task automatic mem_handshake(string name, output bit ok);
		int n;
		ok = 1'b0;
		n = 0;
		@(negedge clk);
		while (!busy && n < 10)
		begin
			@(negedge clk);
			n++;
		end
		if (!busy)
		begin
			note_fault({name, ": busy never went high"});
			return;
		end
		n = 0;
		while (busy && n < 200)
		begin
			if (we6)
				note_fault({name, ": we6 high while busy"});
			if (!core_l15_val && !got_ack)
				note_fault({name, ": request valid dropped before header ack"});
			@(negedge clk);
			n++;
		end
		if (busy)
			note_fault({name, ": busy stuck high, no response seen"});
		else
			ok = 1'b1;
	endtask

	task automatic store_test();
		mem_op_t op;
		word_t a;
		word_t s;
		word_t d;
		word_t ea;
		word_t exp_data;
		l15_size_t exp_size;
		bit ok;
		for (int i = 0; i < 30; i++)
		begin
			op = ($urandom_range(2, 0) == 0) ? mem_sb : ($urandom_range(1, 0) ? mem_sh : mem_sw);
			a = $urandom;
			s = $urandom_range(63, 0);
			d = $urandom;
			ea = align_addr(op, a + s);
			exp_size = (op == mem_sb) ? l15_size_1b : ((op == mem_sh) ? l15_size_2b : l15_size_4b);
			exp_data = (op == mem_sb) ? {4{d[7:0]}} : ((op == mem_sh) ? {2{d[15:0]}} : d);
			@(posedge clk);
			set_nop();
			mem_op4 <= op;
			op_a <= a;
			s_imm4 <= s;
			op_b <= d;
			we4 <= 1'b1;
			rd4 <= reg_addr_t'($urandom);
			@(posedge clk);
			set_nop();
			mem_handshake("store", ok);
			if (ok)
			begin
				test_checks++;
				if (we6)
					note_fault("store: we6 high after the store completed");
				if (cap_rqtype !== l15_store_rq)
					report_value("store rqtype", 32'(l15_store_rq), 32'(cap_rqtype));
				if (cap_size !== exp_size)
					report_value("store size", 32'(exp_size), 32'(cap_size));
				if (cap_addr !== ea)
					report_value("store address", ea, cap_addr);
				if (cap_data !== exp_data)
					report_value("store data", exp_data, cap_data);
			end
		end
		end_test("store");
	endtask

	task automatic load_test();
		mem_op_t op;
		word_t a;
		word_t off;
		word_t ea;
		word_t exp_d;
		reg_addr_t rd;
		bit ok;
		for (int i = 0; i < 60; i++)
		begin
			case ($urandom_range(4, 0))
				0:       op = mem_lb;
				1:       op = mem_lh;
				2:       op = mem_lw;
				3:       op = mem_lbu;
				default: op = mem_lhu;
			endcase
			a = $urandom;
			off = $urandom_range(63, 0);
			rd = reg_addr_t'($urandom);
			ea = align_addr(op, a + off);
			@(posedge clk);
			set_nop();
			mem_op4 <= op;
			op_a <= a;
			op_b <= off;
			wb_sel4 <= wb_mem;
			rd4 <= rd;
			we4 <= 1'b1;
			@(posedge clk);
			set_nop();
			mem_handshake("load", ok);
			if (ok)
			begin
				exp_d = load_model(op, mem_arr[ea[5:2]], ea[1:0]);
				test_checks++;
				if (cap_rqtype !== l15_load_rq)
					report_value("load rqtype", 32'(l15_load_rq), 32'(cap_rqtype));
				if (cap_addr !== ea)
					report_value("load address", ea, cap_addr);
				if (we6 !== 1'b1)
					report_value("load we6", 32'd1, 32'(we6));
				else if (rd6 !== rd)
					report_value("load rd6", 32'(rd), 32'(rd6));
				else if (wb_data6 !== exp_d)
					report_value("load", exp_d, wb_data6);
			end
		end
		if (mem_error)
			note_fault("load: mem_error raised");
		end_test("load");
	endtask

	initial
	begin
		void'($urandom(32'hc1ae_a6dd));
		repeat (4) @(posedge clk);
		nrst <= 1'b1;
		@(negedge clk);
		test_checks++;
		if (we6 || core_l15_val || busy || bjtaken6)
			note_fault("reset: an output is high after reset");
		end_test("reset");
		alu_test();
		branch_test();
		muldiv_test();
		upper_test();
		store_test();
		load_test();
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end
endmodule

// ==== all.f ====
verilog/rv_pkg.sv
verilog/piton_pkg.sv
verilog/alu.sv
verilog/branch_unit.sv
verilog/mul_div.sv
verilog/mem_interface.sv
verilog/core_piton.sv
verilog/exe_stage.sv
verif/exe_stage_assertions.sv
verif/exe_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= exe_stage_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert -j 0

BIN = $(BUILD_DIR)/$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST) -o $(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Some tests failed" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
